// ==== Makefile ====
# Verilator flow for the refill crossbar

TB_TOP := tb_refill_xbar
LOG    := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module refill_xbar
	verilator --lint-only --timing -f flist.f --top-module $(TB_TOP)

obj_dir/V$(TB_TOP): flist.f $(wildcard source/*.sv source/*.svh test/*.sv)
	verilator --binary --timing -j 0 -f flist.f --top-module $(TB_TOP)

# The log decides the result, the simulator status is not trusted
sim: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
+incdir+source
source/refill_addr_pkg.sv
source/refill_xbar_pkg.sv
source/refill_decode.sv
source/refill_arbiter.sv
source/refill_resp_router.sv
source/refill_xbar.sv
test/tb_refill_xbar.sv

// ==== source/refill_addr_pkg.sv ====
/*
  Vector types shared by the request and response paths.
  The channel-side id is the port number on top of the port-side id.
*/
`default_nettype none

`include "refill_consts.svh"

package refill_addr_pkg;

  // Request address, scrambled or not
  typedef logic [`REFILL_ADDR_WIDTH-1:0] addr_t;

  // Index of a DRAM channel
  typedef logic [$clog2(`REFILL_NUM_CHANNELS)-1:0] chan_idx_t;

  // Index of a cache controller port
  typedef logic [$clog2(`REFILL_NUM_PORTS)-1:0] port_idx_t;

  // Id as seen by a cache controller
  typedef logic [`REFILL_ID_WIDTH-1:0] id_t;

  // Id as seen by a channel, {port, id}
  typedef logic [$clog2(`REFILL_NUM_PORTS)+`REFILL_ID_WIDTH-1:0] ext_id_t;

  // One data beat
  typedef logic [`REFILL_DATA_WIDTH-1:0] data_t;

endpackage

`default_nettype wire

// ==== source/refill_arbiter.sv ====
/*
  Round-robin arbiter with a one-entry output register for one channel.
  req_valid_i must already be masked to requests that target this channel.
  The pointer wraps by overflow, so the port count must be a power of two.
*/
`timescale 1ns/1ps
`default_nettype none

`include "refill_consts.svh"

module refill_arbiter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic                       [`REFILL_NUM_PORTS-1:0]   req_valid_i,
  input  refill_xbar_pkg::chan_req_t [`REFILL_NUM_PORTS-1:0]   req_i,
  output logic                       [`REFILL_NUM_PORTS-1:0]   grant_o,
  output logic                                                 chan_req_valid_o,
  output refill_xbar_pkg::chan_req_t                           chan_req_o,
  input  logic                                                 chan_req_ready_i
);

  localparam int unsigned NUM_PORTS = `REFILL_NUM_PORTS;

  // Port with the highest priority in the next round
  refill_addr_pkg::port_idx_t rr_ptr_q;
  refill_addr_pkg::port_idx_t gnt_idx;
  logic                       gnt_any;
  logic                       load_en;

  logic                       out_valid_q;
  refill_xbar_pkg::chan_req_t out_req_q;

  // ----------------------------------------
  // Grant selection
  // ----------------------------------------
  // Room in the register when empty or drained this cycle
  assign load_en = !out_valid_q || chan_req_ready_i;

  // First valid port at or after the pointer
  always_comb begin
    refill_addr_pkg::port_idx_t cand;
    gnt_any = 1'b0;
    gnt_idx = rr_ptr_q;
    for (int i = 0; i < NUM_PORTS; i++) begin
      cand = rr_ptr_q + refill_addr_pkg::port_idx_t'(i);
      if (!gnt_any && req_valid_i[cand]) begin
        gnt_any = 1'b1;
        gnt_idx = cand;
      end
    end
  end

  // A grant doubles as the ready of the winning port
  always_comb begin
    grant_o = '0;
    if (load_en && gnt_any) begin
      grant_o[gnt_idx] = 1'b1;
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
      rr_ptr_q    <= '0;
    end else if (load_en) begin
      out_valid_q <= gnt_any;
      if (gnt_any) begin
        rr_ptr_q <= gnt_idx + refill_addr_pkg::port_idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_en && gnt_any) begin
      out_req_q <= req_i[gnt_idx];
    end
  end

  assign chan_req_valid_o = out_valid_q;
  assign chan_req_o       = out_req_q;

endmodule

`default_nettype wire

// ==== source/refill_consts.svh ====
/*
  Constants of the refill interconnect.
  Port and channel counts must be powers of two.
  Channel spans are aligned to their own size above the DRAM base.
*/
`ifndef REFILL_CONSTS_SVH
`define REFILL_CONSTS_SVH

// ----------------------------------------
// Topology
// ----------------------------------------
`define REFILL_NUM_PORTS     4
`define REFILL_NUM_CHANNELS  4

// ----------------------------------------
// Payload widths
// ----------------------------------------
`define REFILL_ADDR_WIDTH    32
`define REFILL_DATA_WIDTH    64
`define REFILL_ID_WIDTH      2

// ----------------------------------------
// Address map
// ----------------------------------------
`define REFILL_DRAM_BASE     32'h8000_0000
// One channel covers 16 MiB
`define REFILL_CH_SIZE_LOG2  24
// Low bit of the line field swapped with the channel field
`define REFILL_LINE_SEL_LSB  6
// Target of addresses no rule covers
`define REFILL_DEFAULT_CH    3

`endif

// ==== source/refill_decode.sv ====
/*
  Purely combinational, no clock.
  The channel number is read from the scrambled address, so the spans
  must start on a multiple of their own size.
*/
`timescale 1ns/1ps
`default_nettype none

`include "refill_consts.svh"

module refill_decode (
  input  refill_xbar_pkg::port_req_t req_i,
  input  refill_addr_pkg::port_idx_t port_id_i,
  output refill_xbar_pkg::chan_req_t req_o,
  output refill_addr_pkg::chan_idx_t chan_o
);

  // Width of the two swapped fields
  localparam int unsigned FIELD_W   = $clog2(`REFILL_NUM_CHANNELS);
  localparam int unsigned LINE_LSB  = `REFILL_LINE_SEL_LSB;
  localparam int unsigned CH_LSB    = `REFILL_CH_SIZE_LOG2;
  // The last channel has no rule and only takes the default
  localparam int unsigned NUM_RULES = `REFILL_NUM_CHANNELS - 1;

  localparam refill_addr_pkg::addr_t RULE_BASE = `REFILL_DRAM_BASE;
  localparam refill_addr_pkg::addr_t RULE_END  =
    RULE_BASE + (refill_addr_pkg::addr_t'(NUM_RULES) << CH_LSB);

  refill_addr_pkg::addr_t addr_scr;
  logic                   in_rules;

  // ----------------------------------------
  // Address scramble
  // ----------------------------------------
  // Exchange the line field with the channel field, so that
  // neighbouring lines land on different channels
  always_comb begin
    addr_scr                      = req_i.addr;
    addr_scr[LINE_LSB +: FIELD_W] = req_i.addr[CH_LSB +: FIELD_W];
    addr_scr[CH_LSB +: FIELD_W]   = req_i.addr[LINE_LSB +: FIELD_W];
  end

  // ----------------------------------------
  // Channel rule
  // ----------------------------------------
  assign in_rules = (addr_scr >= RULE_BASE) && (addr_scr < RULE_END);

  assign chan_o = in_rules ? refill_addr_pkg::chan_idx_t'(addr_scr[CH_LSB +: FIELD_W])
                           : refill_addr_pkg::chan_idx_t'(`REFILL_DEFAULT_CH);

  // Outgoing request, id prefixed with the source port
  always_comb begin
    req_o.addr   = addr_scr;
    req_o.ext_id = {port_id_i, req_i.id};
    req_o.write  = req_i.write;
    req_o.wdata  = req_i.wdata;
  end

endmodule

`default_nettype wire

// ==== source/refill_resp_router.sv ====
/*
  Zero-latency response router, no state.
  If two channels answer the same port, the lower channel index wins
  and the other one waits with ready low.
*/
`timescale 1ns/1ps
`default_nettype none

`include "refill_consts.svh"

module refill_resp_router (
  input  logic                       [`REFILL_NUM_CHANNELS-1:0] chan_rsp_valid_i,
  input  refill_xbar_pkg::chan_rsp_t [`REFILL_NUM_CHANNELS-1:0] chan_rsp_i,
  output logic                       [`REFILL_NUM_CHANNELS-1:0] chan_rsp_ready_o,
  output logic                       [`REFILL_NUM_PORTS-1:0]    port_rsp_valid_o,
  output refill_xbar_pkg::port_rsp_t [`REFILL_NUM_PORTS-1:0]    port_rsp_o,
  input  logic                       [`REFILL_NUM_PORTS-1:0]    port_rsp_ready_i
);

  localparam int unsigned NUM_PORTS = `REFILL_NUM_PORTS;
  localparam int unsigned NUM_CHANS = `REFILL_NUM_CHANNELS;
  localparam int unsigned ID_W      = `REFILL_ID_WIDTH;
  localparam int unsigned PORT_W    = $clog2(`REFILL_NUM_PORTS);

  // Source port carried in the id prefix of each response
  refill_addr_pkg::port_idx_t [NUM_CHANS-1:0]                rsp_port;
  // One-hot winning channel per port
  logic                       [NUM_PORTS-1:0][NUM_CHANS-1:0] win;

  always_comb begin
    for (int c = 0; c < NUM_CHANS; c++) begin
      rsp_port[c] = chan_rsp_i[c].ext_id[ID_W +: PORT_W];
    end
  end

  // ----------------------------------------
  // Fixed-priority selection per port
  // ----------------------------------------
  always_comb begin
    logic found;
    win = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      found = 1'b0;
      for (int c = 0; c < NUM_CHANS; c++) begin
        if (!found && chan_rsp_valid_i[c] &&
            (rsp_port[c] == refill_addr_pkg::port_idx_t'(p))) begin
          win[p][c] = 1'b1;
          found     = 1'b1;
        end
      end
    end
  end

  // Drive ports with the prefix stripped, return ready to the winner
  always_comb begin
    port_rsp_valid_o = '0;
    port_rsp_o       = '0;
    chan_rsp_ready_o = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int c = 0; c < NUM_CHANS; c++) begin
        if (win[p][c]) begin
          port_rsp_valid_o[p] = 1'b1;
          port_rsp_o[p].id    = chan_rsp_i[c].ext_id[ID_W-1:0];
          port_rsp_o[p].rdata = chan_rsp_i[c].rdata;
          chan_rsp_ready_o[c] = port_rsp_ready_i[p];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/refill_xbar.sv ====
/*
  Refill crossbar from cache controller ports to DRAM channels.
  Requests take one cycle to reach a channel, responses pass combinationally.
  Each beat is a complete request, bursts are not supported.
*/
`timescale 1ns/1ps
`default_nettype none

`include "refill_consts.svh"

module refill_xbar (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  // Cache controller requests
  input  logic                       [`REFILL_NUM_PORTS-1:0]    port_req_valid_i,
  input  refill_xbar_pkg::port_req_t [`REFILL_NUM_PORTS-1:0]    port_req_i,
  output logic                       [`REFILL_NUM_PORTS-1:0]    port_req_ready_o,
  // DRAM channel requests
  output logic                       [`REFILL_NUM_CHANNELS-1:0] chan_req_valid_o,
  output refill_xbar_pkg::chan_req_t [`REFILL_NUM_CHANNELS-1:0] chan_req_o,
  input  logic                       [`REFILL_NUM_CHANNELS-1:0] chan_req_ready_i,
  // DRAM channel responses
  input  logic                       [`REFILL_NUM_CHANNELS-1:0] chan_rsp_valid_i,
  input  refill_xbar_pkg::chan_rsp_t [`REFILL_NUM_CHANNELS-1:0] chan_rsp_i,
  output logic                       [`REFILL_NUM_CHANNELS-1:0] chan_rsp_ready_o,
  // Cache controller responses
  output logic                       [`REFILL_NUM_PORTS-1:0]    port_rsp_valid_o,
  output refill_xbar_pkg::port_rsp_t [`REFILL_NUM_PORTS-1:0]    port_rsp_o,
  input  logic                       [`REFILL_NUM_PORTS-1:0]    port_rsp_ready_i
);

  localparam int unsigned NUM_PORTS = `REFILL_NUM_PORTS;
  localparam int unsigned NUM_CHANS = `REFILL_NUM_CHANNELS;

  refill_xbar_pkg::chan_req_t [NUM_PORTS-1:0]                dec_req;
  refill_addr_pkg::chan_idx_t [NUM_PORTS-1:0]                dec_chan;
  logic                       [NUM_CHANS-1:0][NUM_PORTS-1:0] arb_valid;
  logic                       [NUM_CHANS-1:0][NUM_PORTS-1:0] arb_grant;

  // ----------------------------------------
  // Decode, one per port
  // ----------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_decode
    refill_decode i_decode (
      .req_i     (port_req_i[p]                      ),
      .port_id_i (refill_addr_pkg::port_idx_t'(p)    ),
      .req_o     (dec_req[p]                         ),
      .chan_o    (dec_chan[p]                        )
    );
  end

  // Each arbiter only sees ports aimed at its channel
  always_comb begin
    for (int c = 0; c < NUM_CHANS; c++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        arb_valid[c][p] = port_req_valid_i[p] &&
                          (dec_chan[p] == refill_addr_pkg::chan_idx_t'(c));
      end
    end
  end

  // ----------------------------------------
  // Arbitration and register, one per channel
  // ----------------------------------------
  for (genvar c = 0; c < NUM_CHANS; c++) begin : gen_arbiter
    refill_arbiter i_arbiter (
      .clk_i            (clk_i              ),
      .rst_i            (rst_i              ),
      .req_valid_i      (arb_valid[c]       ),
      .req_i            (dec_req            ),
      .grant_o          (arb_grant[c]       ),
      .chan_req_valid_o (chan_req_valid_o[c]),
      .chan_req_o       (chan_req_o[c]      ),
      .chan_req_ready_i (chan_req_ready_i[c])
    );
  end

  // A port is accepted by whichever channel granted it
  always_comb begin
    port_req_ready_o = '0;
    for (int c = 0; c < NUM_CHANS; c++) begin
      port_req_ready_o = port_req_ready_o | arb_grant[c];
    end
  end

  // ----------------------------------------
  // Response return
  // ----------------------------------------
  refill_resp_router i_resp_router (
    .chan_rsp_valid_i (chan_rsp_valid_i),
    .chan_rsp_i       (chan_rsp_i      ),
    .chan_rsp_ready_o (chan_rsp_ready_o),
    .port_rsp_valid_o (port_rsp_valid_o),
    .port_rsp_o       (port_rsp_o      ),
    .port_rsp_ready_i (port_rsp_ready_i)
  );

endmodule

`default_nettype wire

// ==== source/refill_xbar_pkg.sv ====
/*
  Request and response records on both sides of the refill crossbar.
  One record is one beat. There are no bursts and no byte strobes.
*/
`default_nettype none

package refill_xbar_pkg;

  // ----------------------------------------
  // Port side
  // ----------------------------------------

  // Refill request from a cache controller
  typedef struct packed {
    refill_addr_pkg::addr_t addr;
    refill_addr_pkg::id_t   id;
    logic                   write;
    refill_addr_pkg::data_t wdata;
  } port_req_t;

  // Response delivered back to a cache controller
  typedef struct packed {
    refill_addr_pkg::id_t   id;
    refill_addr_pkg::data_t rdata;
  } port_rsp_t;

  // ----------------------------------------
  // Channel side
  // ----------------------------------------

  // Request towards a DRAM channel, id widened by the port number
  typedef struct packed {
    refill_addr_pkg::addr_t   addr;
    refill_addr_pkg::ext_id_t ext_id;
    logic                     write;
    refill_addr_pkg::data_t   wdata;
  } chan_req_t;

  // Response from a DRAM channel, still carrying the port prefix
  typedef struct packed {
    refill_addr_pkg::ext_id_t ext_id;
    refill_addr_pkg::data_t   rdata;
  } chan_rsp_t;

endpackage

`default_nettype wire

// ==== test/tb_refill_xbar.sv ====
/*
  Random refill traffic on all ports with random channel back-pressure.
  Responses run as independent random traffic with random id prefixes.
  The run is bounded by per-loop cycle limits, the seed is fixed.
*/
`timescale 1ns/1ps
`default_nettype none

`include "refill_consts.svh"

module tb_refill_xbar;

  localparam int NP            = `REFILL_NUM_PORTS;
  localparam int NC            = `REFILL_NUM_CHANNELS;
  localparam int ID_W          = `REFILL_ID_WIDTH;
  localparam int PORT_W        = $clog2(`REFILL_NUM_PORTS);
  localparam int REQS_PER_PORT = 80;
  localparam int RUN_LIMIT     = 5000;
  localparam int DRAIN_LIMIT   = 200;

  logic                                          clk_i;
  logic                                          rst_i;
  logic                       [NP-1:0]           port_req_valid_i;
  refill_xbar_pkg::port_req_t [NP-1:0]           port_req_i;
  logic                       [NP-1:0]           port_req_ready_o;
  logic                       [NC-1:0]           chan_req_valid_o;
  refill_xbar_pkg::chan_req_t [NC-1:0]           chan_req_o;
  logic                       [NC-1:0]           chan_req_ready_i;
  logic                       [NC-1:0]           chan_rsp_valid_i;
  refill_xbar_pkg::chan_rsp_t [NC-1:0]           chan_rsp_i;
  logic                       [NC-1:0]           chan_rsp_ready_o;
  logic                       [NP-1:0]           port_rsp_valid_o;
  refill_xbar_pkg::port_rsp_t [NP-1:0]           port_rsp_o;
  logic                       [NP-1:0]           port_rsp_ready_i;

  // Expected channel requests, indexed by channel * NP + port
  refill_xbar_pkg::chan_req_t exp_q [NC*NP][$];
  // Handshakes seen at the last falling edge, they complete at the next rising one
  logic [NP-1:0] req_fire;
  logic [NC-1:0] rsp_fire;
  logic          rsp_enable;
  int            issued [NP];
  int            accepted;
  int            checked;
  int            rsp_count;
  int            rsp_conflicts;
  int            errors;

  refill_xbar DUT (.*);

  always #50 clk_i = ~clk_i;

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic void ref_request(
    input  refill_xbar_pkg::port_req_t req,
    input  int                         port,
    output refill_xbar_pkg::chan_req_t want,
    output int                         chan
  );
    refill_addr_pkg::addr_t s;
    s = req.addr;
    s[`REFILL_LINE_SEL_LSB +: 2] = req.addr[`REFILL_CH_SIZE_LOG2 +: 2];
    s[`REFILL_CH_SIZE_LOG2 +: 2] = req.addr[`REFILL_LINE_SEL_LSB +: 2];
    // Three spans have rules, the fourth span and everything else use the default
    if (s >= `REFILL_DRAM_BASE &&
        s < `REFILL_DRAM_BASE + (32'd3 << `REFILL_CH_SIZE_LOG2)) begin
      chan = int'(s[`REFILL_CH_SIZE_LOG2 +: 2]);
    end else begin
      chan = `REFILL_DEFAULT_CH;
    end
    want.addr   = s;
    want.ext_id = {refill_addr_pkg::port_idx_t'(port), req.id};
    want.write  = req.write;
    want.wdata  = req.wdata;
  endfunction

  // About one address in five misses the three mapped spans
  function automatic refill_addr_pkg::addr_t random_address();
    refill_addr_pkg::addr_t a;
    a = $urandom;
    if (($urandom % 5) == 0) begin
      case ($urandom % 3)
        0: a[31] = 1'b0;
        1: begin
          a[31:26] = 6'b100000;
          a[7:6]   = 2'b11;
        end
        default: a[31:26] = 6'b100000 | 6'(($urandom % 31) + 1);
      endcase
    end else begin
      a[31:26] = 6'b100000;
      a[7:6]   = 2'($urandom % 3);
    end
    return a;
  endfunction

  function automatic refill_xbar_pkg::port_req_t random_request();
    refill_xbar_pkg::port_req_t r;
    r.addr  = random_address();
    r.id    = refill_addr_pkg::id_t'($urandom);
    r.write = 1'($urandom);
    r.wdata = {$urandom, $urandom};
    return r;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int i = 0; i < NC*NP; i++) begin
      n += exp_q[i].size();
    end
    return n;
  endfunction

  // ----------------------------------------
  // Stimulus, applied after the rising edge
  // ----------------------------------------
  task automatic drive_ports();
    for (int p = 0; p < NP; p++) begin
      if (port_req_valid_i[p] && req_fire[p]) begin
        port_req_valid_i[p] = 1'b0;
      end
      if (!port_req_valid_i[p] && issued[p] < REQS_PER_PORT && ($urandom % 4) != 0) begin
        port_req_i[p]       = random_request();
        port_req_valid_i[p] = 1'b1;
        issued[p]++;
      end
    end
  endtask

  task automatic drive_sinks();
    for (int c = 0; c < NC; c++) begin
      chan_req_ready_i[c] = ($urandom % 4) != 0;
    end
  endtask

  task automatic drive_responses();
    refill_xbar_pkg::chan_rsp_t rsp;
    for (int c = 0; c < NC; c++) begin
      if (chan_rsp_valid_i[c] && rsp_fire[c]) begin
        chan_rsp_valid_i[c] = 1'b0;
      end
      if (!chan_rsp_valid_i[c] && rsp_enable && ($urandom % 2) == 0) begin
        rsp.ext_id          = refill_addr_pkg::ext_id_t'($urandom);
        rsp.rdata           = {$urandom, $urandom};
        chan_rsp_i[c]       = rsp;
        chan_rsp_valid_i[c] = 1'b1;
      end
    end
    for (int p = 0; p < NP; p++) begin
      port_rsp_ready_i[p] = ($urandom % 3) != 0;
    end
  endtask

  // ----------------------------------------
  // Monitors and compare
  // ----------------------------------------
  always @(negedge clk_i) begin
    refill_xbar_pkg::chan_req_t want;
    int chan;
    for (int p = 0; p < NP; p++) begin
      req_fire[p] = port_req_valid_i[p] && port_req_ready_o[p];
      if (req_fire[p]) begin
        ref_request(port_req_i[p], p, want, chan);
        exp_q[chan*NP + p].push_back(want);
        accepted++;
      end
    end
  end

  always @(negedge clk_i) begin
    refill_xbar_pkg::chan_req_t want;
    int idx;
    for (int c = 0; c < NC; c++) begin
      if (chan_req_valid_o[c] && chan_req_ready_i[c]) begin
        idx = c*NP + int'(chan_req_o[c].ext_id[ID_W +: PORT_W]);
        if (exp_q[idx].size() == 0) begin
          errors++;
          $display("CHECK FAILED at %0t: unexpected request on channel %0d, addr %h id %h",
                   $time, c, chan_req_o[c].addr, chan_req_o[c].ext_id);
        end else begin
          want = exp_q[idx].pop_front();
          checked++;
          if (chan_req_o[c] !== want) begin
            errors++;
            $display("CHECK FAILED at %0t: channel %0d got addr %h id %h, expected addr %h id %h",
                     $time, c, chan_req_o[c].addr, chan_req_o[c].ext_id,
                     want.addr, want.ext_id);
          end
        end
      end
    end
  end

  // Response routing by prefix, lowest channel first
  always @(negedge clk_i) begin
    int win;
    for (int c = 0; c < NC; c++) begin
      rsp_fire[c] = chan_rsp_valid_i[c] && chan_rsp_ready_o[c];
    end
    for (int p = 0; p < NP; p++) begin
      win = -1;
      for (int c = 0; c < NC; c++) begin
        if (chan_rsp_valid_i[c] &&
            chan_rsp_i[c].ext_id[ID_W +: PORT_W] == refill_addr_pkg::port_idx_t'(p)) begin
          if (win < 0) begin
            win = c;
          end else begin
            rsp_conflicts++;
            if (chan_rsp_ready_o[c]) begin
              errors++;
              $display("CHECK FAILED at %0t: channel %0d ready ahead of channel %0d for port %0d",
                       $time, c, win, p);
            end
          end
        end
      end
      if (port_rsp_valid_o[p] != (win >= 0)) begin
        errors++;
        $display("CHECK FAILED at %0t: port %0d response valid is %b", $time, p,
                 port_rsp_valid_o[p]);
      end else if (win >= 0) begin
        if (port_rsp_o[p].id != chan_rsp_i[win].ext_id[ID_W-1:0] ||
            port_rsp_o[p].rdata != chan_rsp_i[win].rdata) begin
          errors++;
          $display("CHECK FAILED at %0t: port %0d response id %h data %h, expected from channel %0d",
                   $time, p, port_rsp_o[p].id, port_rsp_o[p].rdata, win);
        end
        if (chan_rsp_ready_o[win] != port_rsp_ready_i[p]) begin
          errors++;
          $display("CHECK FAILED at %0t: channel %0d response ready does not follow port %0d",
                   $time, win, p);
        end
        if (port_rsp_ready_i[p]) begin
          rsp_count++;
        end
      end
    end
  end

  // ----------------------------------------
  // Sequence
  // ----------------------------------------
  initial begin
    int cycles;
    void'($urandom(32'hf598));
    clk_i            = 1'b0;
    rst_i            = 1'b1;
    port_req_valid_i = '0;
    port_req_i       = '0;
    chan_req_ready_i = '0;
    chan_rsp_valid_i = '0;
    chan_rsp_i       = '0;
    port_rsp_ready_i = '0;
    req_fire         = '0;
    rsp_fire         = '0;
    rsp_enable       = 1'b0;
    accepted         = 0;
    checked          = 0;
    rsp_count        = 0;
    rsp_conflicts    = 0;
    errors           = 0;
    for (int p = 0; p < NP; p++) begin
      issued[p] = 0;
    end

    // Channel outputs stay idle in reset and in the first cycle after it
    for (int i = 0; i < 5; i++) begin
      @(posedge clk_i);
      if (i == 4) begin
        #1 rst_i = 1'b0;
      end
      @(negedge clk_i);
      if (chan_req_valid_o !== '0) begin
        errors++;
        $display("CHECK FAILED at %0t: channel valid %b around reset", $time, chan_req_valid_o);
      end
    end

    rsp_enable = 1'b1;
    cycles     = 0;
    while (accepted < NP*REQS_PER_PORT && cycles < RUN_LIMIT) begin
      @(posedge clk_i);
      #1;
      drive_ports();
      drive_sinks();
      drive_responses();
      cycles++;
    end
    if (accepted < NP*REQS_PER_PORT) begin
      errors++;
      $display("Timed out with only %0d of %0d requests accepted", accepted, NP*REQS_PER_PORT);
    end

    // Drain the channel registers
    rsp_enable = 1'b0;
    cycles     = 0;
    while (pending_count() != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk_i);
      #1;
      drive_ports();
      drive_sinks();
      drive_responses();
      cycles++;
    end
    if (pending_count() != 0) begin
      errors++;
      $display("%0d accepted requests never left on a channel", pending_count());
    end
    if (rsp_count == 0 || rsp_conflicts == 0) begin
      errors++;
      $display("Response traffic too thin, %0d delivered and %0d conflicts",
               rsp_count, rsp_conflicts);
    end

    $display("Errors %0d, requests checked %0d of %0d, responses delivered %0d",
             errors, checked, accepted, rsp_count);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
